// ==== hw/scope_cfg.svh ====
// build-time constants for the scope controller; include wherever memory or chip id sizes matter
`ifndef SCOPE_CFG_SVH
`define SCOPE_CFG_SVH

// sample memory geometry
`define SCOPE_RAM_AW 12   // 4096 samples per channel
`define SCOPE_NUM_CH 4    // channels read out in order 0..3

// legal trigger point window
`define SCOPE_TP_MIN 4       // lowest accepted trigger point
`define SCOPE_TP_MARGIN 16   // top limit sits this far below the memory depth

// unique id reply
`define SCOPE_ID_BYTES 8   // 64-bit chip id, sent lsb byte first

`endif

// ==== hw/scope_pkg.sv ====
// types shared by the command parser, the reply engine, the top and the testbench
`default_nettype none
`include "scope_cfg.svh"

package scope_pkg;

	// one sample memory address
	typedef logic [`SCOPE_RAM_AW-1:0] ram_addr_t;

	// command codes this board still understands
	typedef enum logic [7:0] {
		CMD_ID_BASE    = 8'd0,    // 0..9 assigns the board id
		CMD_SEL_BASE   = 8'd10,   // 10..19 selects a board for readout
		CMD_LAST_BASE  = 8'd20,   // 20..29 marks the last board of the chain
		CMD_ARM        = 8'd100,
		CMD_ROLL_ON    = 8'd101,
		CMD_ROLL_OFF   = 8'd102,
		CMD_TRIG_POINT = 8'd121,  // two extra bytes, high first
		CMD_SAMPLES    = 8'd122,  // two extra bytes, high first
		CMD_STRIDE     = 8'd123,  // one extra byte
		CMD_THRESH     = 8'd127,  // one extra byte
		CMD_TRIG_TYPE  = 8'd128,  // one extra byte
		CMD_CHIP_ID    = 8'd142
	} cmd_code_t;

	// board settings written by the parameter commands
	typedef struct packed {
		ram_addr_t   trig_point;       // samples kept before the trigger
		ram_addr_t   samples_to_send;  // 0 means the whole memory
		logic [3:0]  send_log2_stride; // address step is 2**stride
		logic [7:0]  trig_thresh;
		logic [3:0]  trig_type;        // bit 0 rising edge
		logic        rolling;          // rolling trigger on
	} scope_settings_t;

	// what the reply engine must send
	typedef enum logic {
		REPLY_CHIP_ID = 1'b0,
		REPLY_SAMPLES = 1'b1
	} reply_kind_t;

	typedef struct packed {
		logic        valid;  // one-cycle request strobe
		reply_kind_t kind;
	} reply_req_t;

	// one byte per channel from the four sample memories, channel 0 in the low byte
	typedef logic [`SCOPE_NUM_CH-1:0][7:0] chan_bytes_t;

endpackage

`default_nettype wire

// ==== hw/cmd_parser.sv ====
// decodes the upstream command stream, forwards it downstream and holds board identity and settings
`timescale 1ns/1ps
`default_nettype none
`include "scope_cfg.svh"

module cmd_parser import scope_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              rx_valid,     // one strobe per upstream byte
	input  wire  [7:0]       rx_data,
	input  wire              busy,         // reply engine still sending
	output logic             fwd_valid,
	output logic [7:0]       fwd_data,
	output scope_settings_t  settings,
	output logic [7:0]       board_id,
	output logic             passthrough,
	output logic             is_last,
	output logic             arm,
	output reply_req_t       req
);

	localparam logic [7:0]  GROUP_SPAN = 8'd10;  // width of the id, select and last groups
	localparam logic [15:0] TP_MIN = 16'(`SCOPE_TP_MIN);
	localparam logic [15:0] TP_MAX = 16'((1 << `SCOPE_RAM_AW) - `SCOPE_TP_MARGIN);
	localparam ram_addr_t   TP_GUARD = ram_addr_t'(5);  // trig point must stay this far inside

	localparam scope_settings_t SETTINGS_RST = '{
		trig_point:       ram_addr_t'(1024),
		samples_to_send:  '0,
		send_log2_stride: 4'd0,
		trig_thresh:      8'h80,
		trig_type:        4'b0001,
		rolling:          1'b1
	};

	typedef enum logic [1:0] {P_IDLE, P_GATHER, P_WAIT} state_t;

	state_t     state;
	cmd_code_t  cmd_q;       // parameter command being gathered
	logic       got_hi;      // high byte of a two-byte argument is in
	logic [7:0] hi_byte;
	logic [15:0] arg_word;   // high byte with the byte arriving now
	ram_addr_t  tp_clamped;
	ram_addr_t  samples_new;

	always_comb begin
		arg_word = {hi_byte, rx_data};
		if (arg_word > TP_MAX)
			tp_clamped = TP_MAX[`SCOPE_RAM_AW-1:0];
		else if (arg_word < TP_MIN)
			tp_clamped = TP_MIN[`SCOPE_RAM_AW-1:0];
		else
			tp_clamped = arg_word[`SCOPE_RAM_AW-1:0];
		samples_new = arg_word[`SCOPE_RAM_AW-1:0];  // upper bits beyond the depth dropped
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= P_IDLE;
			got_hi      <= 1'b0;
			fwd_valid   <= 1'b0;
			arm         <= 1'b0;
			req         <= '0;
			settings    <= SETTINGS_RST;
			board_id    <= 8'd200;  // unassigned until an id command arrives
			passthrough <= 1'b0;
			is_last     <= 1'b0;
		end else begin
			fwd_valid <= 1'b0;  // strobes default low
			arm       <= 1'b0;
			req       <= '0;
			case (state)
				P_IDLE: if (rx_valid) begin
					fwd_data <= rx_data;  // most codes go on unchanged
					if (rx_data < CMD_SEL_BASE) begin
						board_id  <= rx_data - CMD_ID_BASE;
						fwd_data  <= rx_data + 8'd1;  // next board gets the next id
						fwd_valid <= 1'b1;
					end else if (rx_data < CMD_LAST_BASE) begin
						if ((rx_data - CMD_SEL_BASE) == board_id) begin
							passthrough <= 1'b0;  // this board is read out, code stops here
							req         <= '{valid: 1'b1, kind: REPLY_SAMPLES};
							state       <= P_WAIT;
						end else begin
							passthrough <= 1'b1;
							fwd_valid   <= 1'b1;
						end
					end else if (rx_data < CMD_LAST_BASE + GROUP_SPAN) begin
						is_last   <= ((rx_data - CMD_LAST_BASE) == board_id);
						fwd_valid <= 1'b1;
					end else begin
						case (rx_data)
							CMD_ARM: begin
								arm       <= 1'b1;
								fwd_valid <= 1'b1;
							end
							CMD_ROLL_ON, CMD_ROLL_OFF: begin
								settings.rolling <= (rx_data == CMD_ROLL_ON);
								fwd_valid        <= 1'b1;
							end
							CMD_TRIG_POINT, CMD_SAMPLES, CMD_STRIDE, CMD_THRESH,
							CMD_TRIG_TYPE: begin
								cmd_q     <= cmd_code_t'(rx_data);
								got_hi    <= 1'b0;
								fwd_valid <= 1'b1;
								state     <= P_GATHER;
							end
							CMD_CHIP_ID: begin
								if (passthrough) begin
									fwd_valid <= 1'b1;  // another board answers
								end else begin
									req   <= '{valid: 1'b1, kind: REPLY_CHIP_ID};
									state <= P_WAIT;
								end
							end
							default: ;  // unknown code, dropped
						endcase
					end
				end
				P_GATHER: if (rx_valid) begin
					fwd_data  <= rx_data;  // extra bytes go downstream as they come
					fwd_valid <= 1'b1;
					if ((cmd_q == CMD_TRIG_POINT || cmd_q == CMD_SAMPLES) && !got_hi) begin
						hi_byte <= rx_data;
						got_hi  <= 1'b1;
					end else begin
						state <= P_IDLE;
						case (cmd_q)
							CMD_TRIG_POINT: settings.trig_point <= tp_clamped;
							CMD_SAMPLES: begin
								settings.samples_to_send <= samples_new;
								// keep the trigger inside a short readout window
								if (samples_new >= TP_GUARD &&
									settings.trig_point > samples_new - TP_GUARD)
									settings.trig_point <= samples_new >> 1;
							end
							CMD_STRIDE:    settings.send_log2_stride <= rx_data[3:0];
							CMD_THRESH:    settings.trig_thresh <= rx_data;
							CMD_TRIG_TYPE: settings.trig_type <= rx_data[3:0];
							default: ;
						endcase
					end
				end
				P_WAIT: begin
					// busy rises the cycle after req, so hold while the strobe is out
					if (!req.valid && !busy)
						state <= P_IDLE;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/reply_engine.sv ====
// sends the chip id or the four-channel sample readout to the UART one byte per tx_start
`timescale 1ns/1ps
`default_nettype none
`include "scope_cfg.svh"

module reply_engine import scope_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire reply_req_t  req,
	input  wire scope_settings_t settings,
	input  wire  [63:0]      chip_id,
	input  wire ram_addr_t   wr_trig_addr,    // capture address at the trigger
	input  wire              ext_data_ready,
	input  wire chan_bytes_t ram_data,        // one cycle after rd_addr
	input  wire              tx_busy,
	output logic             busy,
	output logic             rd_en,
	output ram_addr_t        rd_addr,
	output logic             tx_start,
	output logic [7:0]       tx_data
);

	localparam int AW    = `SCOPE_RAM_AW;
	localparam int CH_W  = $clog2(`SCOPE_NUM_CH);
	localparam int CNT_W = AW + CH_W;  // channel number sits above the sample count
	localparam int IDX_W = $clog2(`SCOPE_ID_BYTES);

	typedef enum logic [2:0] {R_IDLE, R_ID, R_WAIT, R_FETCH, R_SEND} state_t;

	state_t           state;
	logic [CNT_W-1:0] send_cnt;
	logic [CNT_W-1:0] step;
	logic [CNT_W-1:0] cnt_step;
	logic [CNT_W-1:0] cnt_next;
	logic [CH_W-1:0]  chan;
	logic             restart;   // sample budget used up so the next channel starts
	ram_addr_t        start_addr;
	ram_addr_t        addr_next;
	logic [IDX_W-1:0] byte_idx;
	logic             tx_ready;

	assign chan     = send_cnt[CNT_W-1:AW];
	assign tx_ready = !tx_busy && !tx_start;  // UART raises tx_busy one cycle late

	always_comb begin
		if (settings.send_log2_stride >= AW)
			step = CNT_W'(1) << AW;  // larger strides leave the channel after one sample
		else
			step = CNT_W'(1) << settings.send_log2_stride;
		cnt_step = send_cnt + step;  // carry out of the count moves to the next channel
		restart  = (settings.samples_to_send != '0) &&
			(cnt_step[AW-1:0] >= settings.samples_to_send);
		if (restart) begin
			cnt_next  = {cnt_step[CNT_W-1:AW] + CH_W'(1), {AW{1'b0}}};
			addr_next = start_addr;
		end else begin
			cnt_next  = cnt_step;
			addr_next = rd_addr + step[AW-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= R_IDLE;
			busy     <= 1'b0;
			rd_en    <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				R_IDLE: if (req.valid) begin
					busy     <= 1'b1;
					byte_idx <= '0;
					state    <= (req.kind == REPLY_CHIP_ID) ? R_ID : R_WAIT;
				end
				R_ID: if (tx_ready) begin
					tx_start <= 1'b1;
					tx_data  <= chip_id[8*byte_idx +: 8];  // lsb byte first
					byte_idx <= byte_idx + 1'b1;
					if (byte_idx == IDX_W'(`SCOPE_ID_BYTES - 1)) begin
						busy  <= 1'b0;
						state <= R_IDLE;
					end
				end
				R_WAIT: if (ext_data_ready) begin  // waits as long as the capture takes
					rd_addr    <= wr_trig_addr - settings.trig_point;
					start_addr <= wr_trig_addr - settings.trig_point;
					send_cnt   <= '0;
					rd_en      <= 1'b1;
					state      <= R_FETCH;
				end
				R_FETCH: state <= R_SEND;  // memory latency
				R_SEND: if (tx_ready) begin
					tx_start <= 1'b1;
					tx_data  <= ram_data[chan];
					send_cnt <= cnt_next;
					rd_addr  <= addr_next;
					if (cnt_next == '0) begin  // wrapped past channel 3
						busy  <= 1'b0;
						rd_en <= 1'b0;
						state <= R_IDLE;
					end else begin
						state <= R_FETCH;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/scope_ctrl_top.sv ====
// one board's serial command controller: command parser plus reply engine
`timescale 1ns/1ps
`default_nettype none

module scope_ctrl_top import scope_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              rx_valid,
	input  wire  [7:0]       rx_data,
	output logic             fwd_valid,
	output logic [7:0]       fwd_data,
	output scope_settings_t  settings,
	output logic [7:0]       board_id,
	output logic             passthrough,
	output logic             is_last,
	output logic             arm,
	input  wire  [63:0]      chip_id,
	input  wire ram_addr_t   wr_trig_addr,
	input  wire              ext_data_ready,
	output logic             rd_en,
	output ram_addr_t        rd_addr,
	input  wire chan_bytes_t ram_data,
	input  wire              tx_busy,
	output logic             tx_start,
	output logic [7:0]       tx_data
);

	reply_req_t req;   // parser to engine, one cycle
	logic       busy;  // engine to parser, holds the parser in its wait state

	cmd_parser u_parser (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.busy        (busy),
		.fwd_valid   (fwd_valid),
		.fwd_data    (fwd_data),
		.settings    (settings),
		.board_id    (board_id),
		.passthrough (passthrough),
		.is_last     (is_last),
		.arm         (arm),
		.req         (req)
	);

	reply_engine u_reply (
		.clk            (clk),
		.rst_n          (rst_n),
		.req            (req),
		.settings       (settings),
		.chip_id        (chip_id),
		.wr_trig_addr   (wr_trig_addr),
		.ext_data_ready (ext_data_ready),
		.ram_data       (ram_data),
		.tx_busy        (tx_busy),
		.busy           (busy),
		.rd_en          (rd_en),
		.rd_addr        (rd_addr),
		.tx_start       (tx_start),
		.tx_data        (tx_data)
	);

endmodule

`default_nettype wire

// ==== test/scope_ctrl_assert.sv ====
// handshake assertions bound into scope_ctrl_top by the bind at the bottom of this file
`timescale 1ns/1ps
`default_nettype none

module scope_ctrl_assert (
	input wire clk,
	input wire rst_n,
	input wire tx_start,
	input wire tx_busy,
	input wire fwd_valid,
	input wire arm,
	input wire rd_en,
	input wire busy       // reply engine activity inside the top
);

	int fail_count = 0;  // failed assertions so far

	// uart takes a byte only while idle
	tx_while_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
		else begin
			$error("tx_start issued while tx_busy was high");
			fail_count++;
		end

	// strobes are single cycle
	tx_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |=> !tx_start)
		else begin
			$error("tx_start held for more than one cycle");
			fail_count++;
		end
	fwd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) fwd_valid |=> !fwd_valid)
		else begin
			$error("fwd_valid held for more than one cycle");
			fail_count++;
		end
	arm_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) arm |=> !arm)
		else begin
			$error("arm held for more than one cycle");
			fail_count++;
		end

	// memory reads only happen inside a reply
	rd_only_busy: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !rd_en)
		else begin
			$error("rd_en high while the reply engine is idle");
			fail_count++;
		end

endmodule

bind scope_ctrl_top scope_ctrl_assert u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.tx_start  (tx_start),
	.tx_busy   (tx_busy),
	.fwd_valid (fwd_valid),
	.arm       (arm),
	.rd_en     (rd_en),
	.busy      (busy)
);

`default_nettype wire

// ==== test/tb_scope_ctrl.sv ====
// self-checking testbench for scope_ctrl_top with random commands and a reference model
`timescale 1ns/1ps
`default_nettype none
`include "scope_cfg.svh"

module tb_scope_ctrl import scope_pkg::*; ();

	localparam int DEPTH  = 1 << `SCOPE_RAM_AW;
	localparam int TP_MAX = DEPTH - `SCOPE_TP_MARGIN;

	// observable board state with a count of arm pulses
	typedef struct packed {
		logic [7:0] board_id;
		logic       passthrough;
		logic       is_last;
		logic [7:0] arm_count;
	} board_state_t;

	logic            clk = 1'b0;
	logic            rst_n;
	logic            rx_valid;
	logic [7:0]      rx_data;
	logic [63:0]     chip_id;
	ram_addr_t       wr_trig_addr;
	logic            ext_data_ready;
	chan_bytes_t     ram_data = '0;   // driven by the memory model
	logic            tx_busy = 1'b0;  // driven by the uart model
	logic            fwd_valid;
	logic [7:0]      fwd_data;
	scope_settings_t settings;
	logic [7:0]      board_id;
	logic            passthrough;
	logic            is_last;
	logic            arm;
	logic            rd_en;
	ram_addr_t       rd_addr;
	logic            tx_start;
	logic [7:0]      tx_data;

	logic [7:0]      mem [`SCOPE_NUM_CH][DEPTH];  // four channel sample memories
	logic [7:0]      fwd_exp[$];   // bytes the next board should see
	logic [7:0]      tx_exp[$];    // bytes the uart should see
	scope_settings_t m_set;        // reference settings
	board_state_t    m_board;      // reference identity
	logic [7:0]      arm_seen = 8'd0;
	logic [31:0]     seed = 32'h2bdb_7881;
	logic [31:0]     busy_seed = ~32'h2bdb_7881;  // separate stream for uart busy lengths
	int              busy_left = 0;
	int              cycles = 0;
	int              cycle_limit = 2000;  // grows by 40 per byte sent or expected

	scope_ctrl_top u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.rx_valid       (rx_valid),
		.rx_data        (rx_data),
		.fwd_valid      (fwd_valid),
		.fwd_data       (fwd_data),
		.settings       (settings),
		.board_id       (board_id),
		.passthrough    (passthrough),
		.is_last        (is_last),
		.arm            (arm),
		.chip_id        (chip_id),
		.wr_trig_addr   (wr_trig_addr),
		.ext_data_ready (ext_data_ready),
		.rd_en          (rd_en),
		.rd_addr        (rd_addr),
		.ram_data       (ram_data),
		.tx_busy        (tx_busy),
		.tx_start       (tx_start),
		.tx_data        (tx_data)
	);

	always #10 clk = ~clk;  // 20 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int pick(input int n);  // 0..n-1 from the stimulus stream
		seed = lcg_next(seed);
		return int'(seed[31:8]) % n;
	endfunction

	function automatic board_state_t board_now();
		board_state_t b;
		b.board_id    = board_id;
		b.passthrough = passthrough;
		b.is_last     = is_last;
		b.arm_count   = arm_seen;
		return b;
	endfunction

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// one compare task per result kind
	task automatic check_settings(input scope_settings_t got, input scope_settings_t exp);
		if (got !== exp)
			stop_fail($sformatf("FAILED at %0t: settings %h expected %h (tp %0d/%0d n %0d/%0d)",
				$time, got, exp, got.trig_point, exp.trig_point,
				got.samples_to_send, exp.samples_to_send));
	endtask

	task automatic compare_fwd_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_fail($sformatf("FAILED at %0t: forwarded byte %h expected %h", $time, got, exp));
	endtask

	task automatic verify_tx_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_fail($sformatf("FAILED at %0t: uart byte %h expected %h", $time, got, exp));
	endtask

	task automatic match_board_state(input board_state_t got, input board_state_t exp);
		if (got !== exp)
			stop_fail($sformatf("FAILED at %0t: board %0d/%b/%b/%0d expected %0d/%b/%b/%0d",
				$time, got.board_id, got.passthrough, got.is_last, got.arm_count,
				exp.board_id, exp.passthrough, exp.is_last, exp.arm_count));
	endtask

	// uart busy and the one-cycle memory read both act 1 ns after the edge
	always @(posedge clk) begin
		logic      start_seen;
		logic      rd_seen;
		ram_addr_t addr_seen;
		start_seen = tx_start;
		rd_seen    = rd_en;
		addr_seen  = rd_addr;
		#1;
		if (rd_seen) begin
			for (int c = 0; c < `SCOPE_NUM_CH; c++)
				ram_data[c] = mem[c][addr_seen];
		end
		if (start_seen) begin
			busy_seed = lcg_next(busy_seed);
			busy_left = 1 + int'(busy_seed[31:8]) % 6;  // 1..6 cycles
		end else if (busy_left > 0) begin
			busy_left = busy_left - 1;
		end
		tx_busy = (busy_left != 0);
	end

	// output monitors and watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			stop_fail($sformatf("timeout: run still going after %0d cycles", cycles));
		if (u_dut.u_assert.fail_count != 0)
			stop_fail("a handshake assertion on the DUT failed");
		if (rst_n && fwd_valid) begin
			if (fwd_exp.size() == 0)
				stop_fail($sformatf("unexpected forwarded byte %h at %0t", fwd_data, $time));
			else
				compare_fwd_byte(fwd_data, fwd_exp.pop_front());
		end
		if (rst_n && tx_start) begin
			if (tx_exp.size() == 0)
				stop_fail($sformatf("unexpected uart byte %h at %0t", tx_data, $time));
			else
				verify_tx_byte(tx_data, tx_exp.pop_front());
		end
		if (rst_n && arm)
			arm_seen = arm_seen + 8'd1;
	end

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		#1;
		rx_valid    = 1'b1;
		rx_data     = b;
		cycle_limit = cycle_limit + 40;
		@(posedge clk);
		#1;
		rx_valid = 1'b0;  // one-cycle strobe, then a gap
	endtask

	task automatic expect_tx(input logic [7:0] b);
		tx_exp.push_back(b);
		cycle_limit = cycle_limit + 40;
	endtask

	// four channels from trig address minus trig point stepping by 2**stride
	task automatic predict_readout(input ram_addr_t trig_addr);
		ram_addr_t start_a;
		ram_addr_t a;
		int        ch;
		int        cnt;
		int        step;
		start_a = trig_addr - m_set.trig_point;
		step    = 1 << m_set.send_log2_stride;
		a       = start_a;
		ch      = 0;
		cnt     = 0;
		while (ch < `SCOPE_NUM_CH) begin
			expect_tx(mem[ch][a]);
			cnt = cnt + step;
			if ((m_set.samples_to_send != '0 && cnt >= int'(m_set.samples_to_send)) ||
				cnt >= DEPTH) begin
				ch  = ch + 1;  // budget used or memory wrapped
				cnt = 0;
				a   = start_a;
			end else begin
				a = a + ram_addr_t'(step);
			end
		end
	endtask

	// update the model, send the command, wait for any reply, then compare everything
	task automatic issue_cmd(input logic [7:0] code, input logic [7:0] hi, input logic [7:0] lo,
		input ram_addr_t trig_addr);
		int   n_extra;
		logic reply;
		logic readout;
		int   w;
		n_extra = 0;
		reply   = 1'b0;
		readout = 1'b0;
		w       = int'({hi, lo});
		if (code < 8'd10) begin
			m_board.board_id = code;
			fwd_exp.push_back(code + 8'd1);
		end else if (code < 8'd20) begin
			if ((code - 8'd10) == m_board.board_id) begin
				m_board.passthrough = 1'b0;  // this board answers
				predict_readout(trig_addr);
				reply   = 1'b1;
				readout = 1'b1;
			end else begin
				m_board.passthrough = 1'b1;
				fwd_exp.push_back(code);
			end
		end else if (code < 8'd30) begin
			m_board.is_last = ((code - 8'd20) == m_board.board_id);
			fwd_exp.push_back(code);
		end else begin
			case (code)
				CMD_ARM: begin
					m_board.arm_count = m_board.arm_count + 8'd1;
					fwd_exp.push_back(code);
				end
				CMD_ROLL_ON, CMD_ROLL_OFF: begin
					m_set.rolling = (code == CMD_ROLL_ON);
					fwd_exp.push_back(code);
				end
				CMD_TRIG_POINT: begin
					n_extra = 2;
					if (w > TP_MAX)
						m_set.trig_point = ram_addr_t'(TP_MAX);
					else if (w < `SCOPE_TP_MIN)
						m_set.trig_point = ram_addr_t'(`SCOPE_TP_MIN);
					else
						m_set.trig_point = ram_addr_t'(w);
				end
				CMD_SAMPLES: begin
					n_extra = 2;
					m_set.samples_to_send = ram_addr_t'(w);
					// wraps for counts under 5, so those leave the trigger point alone
					if (m_set.trig_point > m_set.samples_to_send - ram_addr_t'(5))
						m_set.trig_point = m_set.samples_to_send >> 1;
				end
				CMD_STRIDE: begin
					n_extra = 1;
					m_set.send_log2_stride = lo[3:0];
				end
				CMD_THRESH: begin
					n_extra = 1;
					m_set.trig_thresh = lo;
				end
				CMD_TRIG_TYPE: begin
					n_extra = 1;
					m_set.trig_type = lo[3:0];
				end
				CMD_CHIP_ID: begin
					if (m_board.passthrough) begin
						fwd_exp.push_back(code);
					end else begin
						for (int i = 0; i < `SCOPE_ID_BYTES; i++)
							expect_tx(chip_id[8*i +: 8]);  // lsb byte first
						reply = 1'b1;
					end
				end
				default: ;  // unknown, nothing forwarded
			endcase
		end
		if (n_extra > 0)
			fwd_exp.push_back(code);
		if (n_extra == 2)
			fwd_exp.push_back(hi);
		if (n_extra > 0)
			fwd_exp.push_back(lo);
		send_byte(code);
		if (n_extra == 2)
			send_byte(hi);
		if (n_extra > 0)
			send_byte(lo);
		if (readout) begin
			repeat (3) @(posedge clk);
			#1;
			wr_trig_addr   = trig_addr;
			ext_data_ready = 1'b1;  // capture done
		end
		if (reply) begin
			while (tx_exp.size() != 0)
				@(posedge clk);
			#1;
			ext_data_ready = 1'b0;
		end
		repeat (2) @(posedge clk);
		#1;
		if (fwd_exp.size() != 0)
			stop_fail($sformatf("forwarded byte %h never appeared on fwd_data", fwd_exp[0]));
		check_settings(settings, m_set);
		match_board_state(board_now(), m_board);
	endtask

	initial begin
		logic [7:0] code;
		logic [7:0] hi;
		logic [7:0] lo;
		logic [7:0] my_id;
		ram_addr_t  taddr;
		int         kind;
		int         w;
		rst_n          = 1'b0;
		rx_valid       = 1'b0;
		rx_data        = 8'd0;
		wr_trig_addr   = '0;
		ext_data_ready = 1'b0;
		seed           = lcg_next(seed);
		chip_id[63:32] = seed;
		seed           = lcg_next(seed);
		chip_id[31:0]  = seed;
		for (int c = 0; c < `SCOPE_NUM_CH; c++)
			for (int a = 0; a < DEPTH; a++)
				mem[c][a] = 8'(pick(256));
		m_set = '{trig_point: ram_addr_t'(1024), samples_to_send: '0, send_log2_stride: 4'd0,
			trig_thresh: 8'h80, trig_type: 4'b0001, rolling: 1'b1};
		m_board = '{board_id: 8'd200, passthrough: 1'b0, is_last: 1'b0, arm_count: 8'd0};
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		check_settings(settings, m_set);
		match_board_state(board_now(), m_board);

		// random mix of id, last, arm, rolling, parameter and unknown codes
		for (int n = 0; n < 60; n++) begin
			kind = pick(8);
			hi   = 8'(pick(18));   // reaches past the trig point limit
			lo   = 8'(pick(256));
			case (kind)
				0: code = 8'(pick(10));
				1: code = 8'(20 + pick(10));
				2: code = CMD_ARM;
				3: code = (pick(2) == 0) ? CMD_ROLL_ON : CMD_ROLL_OFF;
				4: code = CMD_TRIG_POINT;
				5: code = CMD_SAMPLES;
				6: code = (pick(3) == 0) ? CMD_STRIDE :
					((pick(2) == 0) ? CMD_THRESH : CMD_TRIG_TYPE);
				default: code = (pick(2) == 0) ? 8'(30 + pick(70)) : 8'(143 + pick(113));
			endcase
			issue_cmd(code, hi, lo, '0);
		end

		// trigger point below and above its window
		issue_cmd(CMD_TRIG_POINT, 8'd0, 8'd1, '0);
		issue_cmd(CMD_TRIG_POINT, 8'd255, 8'd255, '0);

		// own id, mark last, then short windows, one full-depth pass and one oversized stride
		my_id = 8'(pick(10));
		issue_cmd(my_id, 8'd0, 8'd0, '0);
		issue_cmd(8'd20 + my_id, 8'd0, 8'd0, '0);
		for (int r = 0; r < 5; r++) begin
			w = (r == 3) ? 0 : 16 + pick(400);
			issue_cmd(CMD_SAMPLES, 8'(w >> 8), 8'(w), '0);
			if (r == 3)
				lo = 8'd3;
			else if (r == 4)
				lo = 8'(12 + pick(4));  // step at or past the memory depth
			else
				lo = 8'(pick(4));
			issue_cmd(CMD_STRIDE, 8'd0, lo, '0);
			hi = 8'(pick(16));
			lo = 8'(pick(256));
			issue_cmd(CMD_TRIG_POINT, hi, lo, '0);
			taddr = ram_addr_t'(pick(DEPTH));
			issue_cmd(8'd10 + my_id, 8'd0, 8'd0, taddr);
		end

		// chip id answered here, then forwarded once another board is selected
		issue_cmd(CMD_CHIP_ID, 8'd0, 8'd0, '0);
		issue_cmd(8'd10 + 8'((int'(my_id) + 1) % 10), 8'd0, 8'd0, '0);
		issue_cmd(CMD_CHIP_ID, 8'd0, 8'd0, '0);
		issue_cmd(CMD_ARM, 8'd0, 8'd0, '0);
		issue_cmd(CMD_ROLL_OFF, 8'd0, 8'd0, '0);
		issue_cmd(CMD_ROLL_ON, 8'd0, 8'd0, '0);

		if (fwd_exp.size() != 0 || tx_exp.size() != 0 || u_dut.u_assert.fail_count != 0) begin
			stop_fail("run ended with expected bytes outstanding or a failed assertion");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/scope_pkg.sv
hw/cmd_parser.sv
hw/reply_engine.sv
hw/scope_ctrl_top.sv
test/scope_ctrl_assert.sv
test/tb_scope_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build the scope controller testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_scope_ctrl \
	-Mdir obj_dir \
	-o sim_scope_ctrl \
	-f flist.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sim_scope_ctrl
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished with status 0"
exit 0
